// File: lif_core.f
+incdir+src
src/lif_pkg.sv
src/weight_mem.sv
src/weight_arbiter.sv
src/synapse_accum.sv
src/lif_neuron.sv
src/lif_core.sv
verification/lif_core_tb.sv

// File: Makefile
# Verilator build and run for lif_core
VERILATOR  ?= verilator
TOP        ?= lif_core_tb
RTL_TOP    ?= lif_core
FILELIST   ?= lif_core.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/lif_core_tb.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

module lif_core_tb
    import lif_pkg::*;
();

    localparam int N               = `LIF_N_NEURONS;
    localparam int NA              = `LIF_N_AXONS;
    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 10;     // Inputs change after the edge
    localparam int STEP_TIMEOUT    = 80;     // Cycles allowed per step
    localparam int TOTAL_STEPS     = 61;
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS * STEP_TIMEOUT + 600;  // Loads and writes

    logic                clk;
    logic                rst_n;
    logic                step;
    axon_mask_t          axons;
    vmem_t               cfg_threshold;
    leak_t               cfg_leak;
    vmem_t               cfg_reset_potential;
    refrac_t             cfg_refractory;
    logic                wr_en;
    waddr_t              wr_addr;
    weight_t             wr_data;
    logic [N-1:0]        spikes;
    vmem_t [N-1:0]       vmem_all;
    logic                busy;
    logic                step_done;

    // Reference model
    weight_t             shadow [0:(1 << `LIF_WADDR_W) - 1];
    int                  model_v [N];
    int                  model_r [N];   // Refractory steps left
    logic [N-1:0]        exp_spikes;
    vmem_t [N-1:0]       exp_vmem;

    int                  errors;
    int                  err_base;
    int                  tests_run;
    int                  tests_failed;
    integer              seed;
    logic                done_seen;     // step_done already seen for this step

    lif_core dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .step                (step),
        .axons               (axons),
        .cfg_threshold       (cfg_threshold),
        .cfg_leak            (cfg_leak),
        .cfg_reset_potential (cfg_reset_potential),
        .cfg_refractory      (cfg_refractory),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .spikes              (spikes),
        .vmem_all            (vmem_all),
        .busy                (busy),
        .step_done           (step_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Reporting
    // ==================================================
    task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("[%0t] %s: passed", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: failed with %0d errors", $time, name, errors - err_base);
        end
        err_base = errors;
    endtask

    // ==================================================
    // Checks
    // ==================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_seen <= 1'b0;
        end else if (step && !busy) begin
            done_seen <= 1'b0;   // New step accepted
        end else if (step_done) begin
            done_seen <= 1'b1;
        end
    end

    spikes_match: assert property (@(posedge clk) disable iff (!rst_n)
        step_done |-> (spikes == exp_spikes))
        else report_value("spikes", 64'(exp_spikes), 64'(spikes));

    vmem_match: assert property (@(posedge clk) disable iff (!rst_n)
        step_done |-> (vmem_all == exp_vmem))
        else report_value("vmem_all", 64'(exp_vmem), 64'(vmem_all));

    single_done: assert property (@(posedge clk) disable iff (!rst_n)
        step_done |-> !done_seen)
        else report_problem("step_done pulsed twice without a step in between");

    // ==================================================
    // Stimulus helpers
    // ==================================================
    task automatic write_weight(input waddr_t addr, input weight_t data);
        wr_en        = 1'b1;
        wr_addr      = addr;
        wr_data      = data;
        shadow[addr] = data;
        @(posedge clk);
        #DRIVE_DLY;
        wr_en = 1'b0;
    endtask

    task automatic set_config(input int thr, input int leak, input int rst_pot, input int refr);
        cfg_threshold       = vmem_t'(thr);
        cfg_leak            = leak_t'(leak);
        cfg_reset_potential = vmem_t'(rst_pot);
        cfg_refractory      = refrac_t'(refr);
    endtask

    // Neuron rules on the summed weights of the set axons
    task automatic model_step(input axon_mask_t mask);
        int sum;
        int v;
        for (int n = 0; n < N; n++) begin
            sum = 0;
            for (int a = 0; a < NA; a++) begin
                if (mask[a]) begin
                    sum += int'(shadow[n * NA + a]);
                end
            end
            if (sum > 32767) sum = 32767;     // 16-bit signed sum
            if (sum < -32768) sum = -32768;
            if (model_r[n] != 0) begin
                model_r[n]--;                 // Held, input ignored
                exp_spikes[n] = 1'b0;
            end else begin
                v = model_v[n] - int'(cfg_leak);
                if (v < 0) v = 0;
                v += sum;
                if (v < 0) v = 0;
                if (v > 65535) v = 65535;
                if (v >= int'(cfg_threshold)) begin
                    exp_spikes[n] = 1'b1;
                    model_v[n]    = int'(cfg_reset_potential);
                    model_r[n]    = int'(cfg_refractory);
                end else begin
                    exp_spikes[n] = 1'b0;
                    model_v[n]    = v;
                end
            end
            exp_vmem[n] = vmem_t'(model_v[n]);
        end
    endtask

    // One timestep, optionally with a host write in the step cycle
    task automatic run_step(input axon_mask_t mask, input logic with_wr,
                            input waddr_t addr, input weight_t data);
        logic got;
        if (with_wr) begin
            wr_en        = 1'b1;
            wr_addr      = addr;
            wr_data      = data;
            shadow[addr] = data;   // Lands before the first read
        end
        model_step(mask);
        step  = 1'b1;
        axons = mask;
        @(posedge clk);
        #DRIVE_DLY;
        step  = 1'b0;
        wr_en = 1'b0;
        got   = 1'b0;
        for (int i = 0; i < STEP_TIMEOUT && !got; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            got = step_done;
        end
        if (!got) begin
            report_problem("step_done did not arrive for a step");
        end
        @(posedge clk);    // Assertions sample here
        #DRIVE_DLY;
    endtask

    task automatic plain_step(input axon_mask_t mask);
        run_step(mask, 1'b0, '0, '0);
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: simulation ran past %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ==================================================
    // Tests
    // ==================================================
    initial begin
        int nwr;
        rst_n = 1'b0;
        step  = 1'b0;
        axons = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        set_config(0, 0, 0, 0);
        seed         = 32'h573d6b3d;
        errors       = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_spikes   = '0;
        exp_vmem     = '0;
        for (int n = 0; n < N; n++) begin
            model_v[n] = 0;
            model_r[n] = 0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Outputs idle after reset
        assert (spikes == '0) else report_value("spikes", 0, 64'(spikes));
        assert (vmem_all == '0) else report_value("vmem_all", 0, 64'(vmem_all));
        assert (busy == 1'b0) else report_value("busy", 0, 64'(busy));
        assert (step_done == 1'b0) else report_value("step_done", 0, 64'(step_done));
        end_test("reset_state");

        // Row n holds 10*(n+1), full mask sums 80..320
        set_config(100, 0, 5, 0);
        for (int a = 0; a < N * NA; a++) begin
            write_weight(waddr_t'(a), weight_t'(10 * (a / NA + 1)));
        end
        plain_step(8'hFF);
        for (int i = 0; i < 3; i++) begin
            plain_step(8'h0F);          // Smaller sums build up
        end
        plain_step(8'h01);
        plain_step(8'h00);
        plain_step(8'hFF);
        plain_step(8'h03);
        end_test("integrate_fire");

        // Negative rows floor at zero, big rows saturate
        set_config(1000, 200, 0, 0);
        for (int a = 0; a < N * NA; a++) begin
            case (a / NA)
                0:       write_weight(waddr_t'(a), -8'sd100);
                1:       write_weight(waddr_t'(a), -8'sd1);
                2:       write_weight(waddr_t'(a), 8'sd100);
                default: write_weight(waddr_t'(a), 8'sd127);
            endcase
        end
        plain_step(8'hFF);
        plain_step(8'h0F);
        plain_step(8'h00);
        plain_step(8'hFF);
        set_config(10, 0, 64000, 0);    // Park upper rows near the top
        plain_step(8'hFF);
        cfg_threshold = 16'hFFFF;
        plain_step(8'hFF);
        plain_step(8'hFF);              // Clamp at 65535, fires
        end_test("leak_clamp");

        // Refractory of 3 steps, nonzero reset level and leak
        set_config(200, 5, 20, 3);
        for (int a = 0; a < N * NA; a++) begin
            write_weight(waddr_t'(a), 8'sd50);
        end
        plain_step(8'hFF);              // All fire, hold starts
        plain_step(8'h00);
        plain_step(8'h0F);
        plain_step(8'hFF);              // Last held step
        plain_step(8'h01);              // Integrates again below threshold
        plain_step(8'hFF);
        end_test("refractory");

        // Random masks and weights, all four lanes fight for the memory
        set_config(300, 10, 0, 2);
        for (int a = 0; a < N * NA; a++) begin
            write_weight(waddr_t'(a), weight_t'($random(seed)));
        end
        for (int i = 0; i < 40; i++) begin
            nwr = {$random(seed)} % 4;
            for (int w = 0; w < nwr; w++) begin     // Writes in the idle gap
                write_weight(waddr_t'($random(seed)), weight_t'($random(seed)));
            end
            if (i % 10 == 0 || i % 10 == 5) begin
                run_step(8'h00, 1'b0, '0, '0);
            end else if (i % 10 == 7) begin
                run_step(8'hFF, 1'($random(seed)), waddr_t'($random(seed)),
                         weight_t'($random(seed)));
            end else begin
                run_step(axon_mask_t'($random(seed)), 1'($random(seed)),
                         waddr_t'($random(seed)), weight_t'($random(seed)));
            end
        end
        end_test("contention");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/lif_core.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

// Four LIF neurons sharing one weight memory
module lif_core
    import lif_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         step,
    input  axon_mask_t                   axons,
    input  vmem_t                        cfg_threshold,
    input  leak_t                        cfg_leak,
    input  vmem_t                        cfg_reset_potential,
    input  refrac_t                      cfg_refractory,
    input  logic                         wr_en,       // Host weight write
    input  waddr_t                       wr_addr,
    input  weight_t                      wr_data,
    output logic   [`LIF_N_NEURONS-1:0]  spikes,
    output vmem_t  [`LIF_N_NEURONS-1:0]  vmem_all,
    output logic                         busy,
    output logic                         step_done    // After all four updated
);

    localparam int N = `LIF_N_NEURONS;

    // Memory port
    logic    mem_en;
    logic    mem_we;
    waddr_t  mem_addr;
    weight_t mem_wdata;
    weight_t mem_rdata;

    // Accumulator side of the arbiter
    logic   [N-1:0] rd_req;
    waddr_t [N-1:0] rd_addr;
    logic   [N-1:0] rd_valid;
    weight_t        rd_data;

    logic   [N-1:0] upd;
    syn_t   [N-1:0] syn;
    logic   [N-1:0] acc_busy;
    logic   [N-1:0] updated_q;    // Neuron has updated this step
    logic           step_go;
    logic           all_now;

    assign busy    = |acc_busy;
    assign step_go = step && !busy;   // Steps during a busy window are dropped

    weight_mem u_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    weight_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // ==================================================
    // Per-neuron lanes
    // ==================================================
    for (genvar g = 0; g < N; g++) begin : g_lane
        synapse_accum u_acc (
            .clk         (clk),
            .rst_n       (rst_n),
            .step        (step_go),
            .axons       (axons),
            .neuron_base (waddr_t'(g * `LIF_N_AXONS)),  // Weight row of lane g
            .rd_req      (rd_req[g]),
            .rd_addr     (rd_addr[g]),
            .rd_valid    (rd_valid[g]),
            .rd_data     (rd_data),
            .upd         (upd[g]),
            .syn         (syn[g]),
            .busy        (acc_busy[g])
        );

        lif_neuron u_neuron (
            .clk                 (clk),
            .rst_n               (rst_n),
            .upd                 (upd[g]),
            .syn                 (syn[g]),
            .cfg_threshold       (cfg_threshold),
            .cfg_leak            (cfg_leak),
            .cfg_reset_potential (cfg_reset_potential),
            .cfg_refractory      (cfg_refractory),
            .spike               (spikes[g]),
            .vmem                (vmem_all[g])
        );
    end

    // ==================================================
    // Step completion
    // ==================================================
    // Last upd of the step is being sampled this cycle
    assign all_now = (&(updated_q | upd)) && !(&updated_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            updated_q <= '0;
            step_done <= 1'b0;
        end else begin
            if (step_go) begin
                updated_q <= '0;         // No upd can coincide, lanes are idle
            end else begin
                updated_q <= updated_q | upd;
            end
            step_done <= all_now;        // Lands with the neuron outputs
        end
    end

endmodule

// File: src/lif_neuron.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

// Single leaky integrate-and-fire neuron, updated once per upd pulse
module lif_neuron
    import lif_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    upd,                  // Sum on syn is valid
    input  syn_t    syn,
    input  vmem_t   cfg_threshold,
    input  leak_t   cfg_leak,
    input  vmem_t   cfg_reset_potential,
    input  refrac_t cfg_refractory,
    output logic    spike,                // Held until next upd
    output vmem_t   vmem
);

    localparam int VW = `LIF_VMEM_W;
    localparam int LW = `LIF_LEAK_W;

    vmem_t              vmem_q;
    refrac_t            refrac_q;
    logic signed [VW+1:0] after_leak;     // Two extra bits, sign and carry
    logic signed [VW+1:0] after_syn;
    vmem_t              vmem_next;
    logic               fire;

    // ==================================================
    // Dynamics, combinational
    // ==================================================
    always_comb begin
        // Leak, floored at zero
        after_leak = $signed({2'b00, vmem_q}) - $signed({{(VW+2-LW){1'b0}}, cfg_leak});
        if (after_leak < 0) begin
            after_leak = '0;
        end

        // Synaptic input, sign extended
        after_syn = after_leak + $signed({{2{syn[VW-1]}}, syn});

        // Clamp into 0 .. 65535
        if (after_syn < 0) begin
            vmem_next = '0;
        end else if (after_syn[VW]) begin
            vmem_next = '1;
        end else begin
            vmem_next = after_syn[VW-1:0];
        end
    end

    assign fire = (vmem_next >= cfg_threshold);

    // ==================================================
    // State update
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vmem_q   <= '0;
            refrac_q <= '0;
            spike    <= 1'b0;
        end else if (upd) begin
            if (refrac_q != '0) begin
                refrac_q <= refrac_q - refrac_t'(1);   // Input ignored, vmem frozen
                spike    <= 1'b0;
            end else if (fire) begin
                spike    <= 1'b1;
                vmem_q   <= cfg_reset_potential;
                refrac_q <= cfg_refractory;
            end else begin
                spike    <= 1'b0;
                vmem_q   <= vmem_next;
            end
        end
    end

    assign vmem = vmem_q;

endmodule

// File: src/synapse_accum.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

// Walks the set axons of one step, fetches a weight per axon and
// hands the signed sum to its neuron
module synapse_accum
    import lif_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       step,         // Timestep strobe
    input  axon_mask_t axons,
    input  waddr_t     neuron_base,  // Row offset of this neuron
    output logic       rd_req,
    output waddr_t     rd_addr,
    input  logic       rd_valid,
    input  weight_t    rd_data,
    output logic       upd,          // One-cycle pulse to the neuron
    output syn_t       syn,
    output logic       busy
);

    localparam int AX_IDX_W = $clog2(`LIF_N_AXONS);
    localparam int SW       = `LIF_VMEM_W;

    accum_state_t          state_q;
    axon_mask_t            mask_q;      // Axons still to fetch
    axon_mask_t            mask_rest;
    syn_t                  sum_q;
    logic signed [SW:0]    sum_wide;    // One guard bit
    syn_t                  sum_sat;

    // Index of the lowest set axon
    function automatic logic [AX_IDX_W-1:0] lowest_idx(input axon_mask_t m);
        logic [AX_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `LIF_N_AXONS - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = AX_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign mask_rest = mask_q & (mask_q - axon_mask_t'(1));  // Drop lowest bit

    // ==================================================
    // Request side
    // ==================================================
    assign rd_req  = ((state_q == ACC_SCAN) && (mask_q != '0)) || (state_q == ACC_WAIT);
    assign rd_addr = neuron_base + waddr_t'(lowest_idx(mask_q));

    // Saturating add of the incoming weight
    assign sum_wide = {sum_q[SW-1], sum_q} + (SW+1)'(rd_data);
    always_comb begin
        if (sum_wide[SW] != sum_wide[SW-1]) begin
            sum_sat = sum_wide[SW] ? {1'b1, {(SW-1){1'b0}}} : {1'b0, {(SW-1){1'b1}}};
        end else begin
            sum_sat = sum_wide[SW-1:0];
        end
    end

    // ==================================================
    // FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ACC_IDLE;
            mask_q  <= '0;
        end else begin
            case (state_q)
                ACC_IDLE: if (step) begin       // Busy steps never get here
                    mask_q  <= axons;
                    state_q <= ACC_SCAN;
                end
                ACC_SCAN: state_q <= (mask_q == '0) ? ACC_FIRE : ACC_WAIT;
                ACC_WAIT: if (rd_valid) begin
                    mask_q  <= mask_rest;
                    state_q <= (mask_rest == '0) ? ACC_FIRE : ACC_SCAN;
                end
                ACC_FIRE: state_q <= ACC_IDLE;
                default:  state_q <= ACC_IDLE;
            endcase
        end
    end

    // Running sum, cleared at step start
    always_ff @(posedge clk) begin
        if ((state_q == ACC_IDLE) && step) begin
            sum_q <= '0;
        end else if ((state_q == ACC_WAIT) && rd_valid) begin
            sum_q <= sum_sat;
        end
    end

    assign upd  = (state_q == ACC_FIRE);
    assign syn  = sum_q;
    assign busy = (state_q != ACC_IDLE);

endmodule

// File: src/weight_arbiter.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

// Owns the weight memory port
// Host write has absolute priority, reads are round-robin
module weight_arbiter
    import lif_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,      // Host write strobe
    input  waddr_t                       wr_addr,
    input  weight_t                      wr_data,
    input  logic   [`LIF_N_NEURONS-1:0]  rd_req,     // Held until rd_valid
    input  waddr_t [`LIF_N_NEURONS-1:0]  rd_addr,
    output logic   [`LIF_N_NEURONS-1:0]  rd_valid,   // Only to the granted one
    output weight_t                      rd_data,    // Broadcast
    output logic                         mem_en,
    output logic                         mem_we,
    output waddr_t                       mem_addr,
    output weight_t                      mem_wdata,
    input  weight_t                      mem_rdata
);

    localparam int N     = `LIF_N_NEURONS;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0]     grant;
    logic [N-1:0]     grant_q;     // Grant of last cycle, data lands now
    logic [N-1:0]     req_open;
    logic [IDX_W-1:0] last_q;      // Last winner
    logic [IDX_W-1:0] win_idx;
    logic [IDX_W-1:0] cand;
    logic             found;

    // Requester with data in flight still holds rd_req, skip it
    assign req_open = rd_req & ~grant_q;

    // ==================================================
    // Round-robin pick, search starts after last winner
    // ==================================================
    always_comb begin
        grant   = '0;
        win_idx = last_q;
        found   = 1'b0;
        cand    = last_q;
        for (int i = 1; i <= N; i++) begin
            cand = IDX_W'((int'(last_q) + i) % N);
            if (!found && !wr_en && req_open[cand]) begin  // Host write blocks all
                grant[cand] = 1'b1;
                win_idx     = cand;
                found       = 1'b1;
            end
        end
    end

    // Memory port mux
    assign mem_we    = wr_en;
    assign mem_en    = found;
    assign mem_addr  = wr_en ? wr_addr : rd_addr[win_idx];
    assign mem_wdata = wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
            last_q  <= IDX_W'(N - 1);   // So accumulator 0 goes first
        end else begin
            grant_q <= grant;
            if (found) begin
                last_q <= win_idx;
            end
        end
    end

    assign rd_valid = grant_q;     // Lines up with registered mem read
    assign rd_data  = mem_rdata;

endmodule

// File: src/weight_mem.sv
`timescale 1ns/100ps
`include "lif_core_defines.svh"

// Shared synaptic weight store, one row of 8 weights per neuron
module weight_mem
    import lif_pkg::*;
(
    input  logic    clk,
    input  logic    en,     // Read enable
    input  logic    we,     // Write enable
    input  waddr_t  addr,
    input  weight_t wdata,
    output weight_t rdata   // Valid one cycle after en
);

    localparam int DEPTH = 1 << `LIF_WADDR_W;   // 32 entries

    weight_t mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, arbiter never asks for both in one cycle
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];   // Holds last value otherwise
        end
    end

endmodule

// File: src/lif_pkg.sv
`include "lif_core_defines.svh"

package lif_pkg;

    // ==================================================
    // Datapath vectors
    // ==================================================
    typedef logic signed [`LIF_W_W-1:0]    weight_t;    // One synaptic weight
    typedef logic signed [`LIF_VMEM_W-1:0] syn_t;       // Summed synaptic input
    typedef logic [`LIF_VMEM_W-1:0]        vmem_t;      // Potential and threshold
    typedef logic [`LIF_LEAK_W-1:0]        leak_t;
    typedef logic [`LIF_REFRAC_W-1:0]      refrac_t;
    typedef logic [`LIF_N_AXONS-1:0]       axon_mask_t; // One bit per axon
    typedef logic [`LIF_WADDR_W-1:0]       waddr_t;

    // ==================================================
    // Accumulator FSM
    // ==================================================
    typedef enum logic [1:0] {
        ACC_IDLE = 2'd0,   // Waiting for a step
        ACC_SCAN = 2'd1,   // New axon picked, request raised
        ACC_WAIT = 2'd2,   // Holding request until read data
        ACC_FIRE = 2'd3    // Sum ready, pulse the neuron
    } accum_state_t;

endpackage

// File: src/lif_core_defines.svh
`ifndef LIF_CORE_DEFINES_SVH
`define LIF_CORE_DEFINES_SVH

// ==================================================
// Core sizing
// ==================================================
`define LIF_N_NEURONS 4   // Neurons in the core
`define LIF_N_AXONS 8     // Input axons per timestep

// Weight address is neuron * 8 + axon
`define LIF_WADDR_W 5
`define LIF_W_W 8         // Signed weight

// ==================================================
// Neuron datapath widths
// ==================================================
`define LIF_VMEM_W 16     // Membrane potential, also the synaptic sum
`define LIF_LEAK_W 8
`define LIF_REFRAC_W 4    // Refractory counter

`endif
